// File: verification/msm_input.txt
# Each test: count N, then N lines "scalar_hex x y", then expected "inf x y" (affine)
# Curve y^2 = x^3 + 7 mod 8191: G = (1,256), 2G = (2302,3970), 3G = (3004,7114)
1
01 1 256
0 1 256
1
02 1 256
0 2302 3970
1
03 1 256
0 3004 7114
2
01 1 256
01 1 256
0 2302 3970
4
c5 1 256
6b 2302 3970
ea 1 7935
3a 3004 1077
0 3004 7114
3
00 1 256
00 2302 3970
00 3004 7114
1 0 0

// File: compile.f
logic/field_pkg.sv
logic/curve_pkg.sv
logic/mod_mul_pipe.sv
logic/mul_arbiter.sv
logic/ec_pt_add.sv
logic/ec_pt_dbl.sv
logic/msm_core.sv
logic/msm_top.sv
verification/msm_assert.sv
verification/tb_msm.sv

// File: Makefile
# Verilator build and run of the MSM testbench

VERILATOR ?= verilator
TOP       ?= tb_msm
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_msm.sv
// MSM testbench with file-driven scalar/point runs checked projectively against affine results
`timescale 1ns/1ps
`default_nettype none

module tb_msm;
  import field_pkg::*;
  import curve_pkg::*;

  localparam int P        = 8191;
  localparam int KEY_BITS = 8;
  localparam int MAX_WAIT = 20000;   // Cycles allowed per run

  logic        i_clk;
  logic        i_rst;
  msm_item_t   i_item;
  logic        i_item_val;
  logic        o_item_rdy;
  logic [15:0] i_num_in;
  jac_pt_t     o_res;
  logic        o_res_val;
  logic        i_res_rdy;

  msm_item_t   items[$];   // Point/scalar list of the current run
  int          fd;
  int          test_cnt;

  msm_top #(
    .P        (P),
    .KEY_BITS (KEY_BITS)
  ) uut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_item     (i_item),
    .i_item_val (i_item_val),
    .o_item_rdy (o_item_rdy),
    .i_num_in   (i_num_in),
    .o_res      (o_res),
    .o_res_val  (o_res_val),
    .i_res_rdy  (i_res_rdy)
  );

  always #4 i_clk = ~i_clk;   // 8 ns period

  function automatic int mod_mul(input int a, input int b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return int'(prod % P);
  endfunction

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic reject_line(input string line);
    $display("Malformed or missing line in stimulus file: %s", line);
    end_with_failure();
  endtask

  // Skips blank lines and comments
  task automatic read_line(output string line, output bit ok);
    string s;
    int    rc;
    ok   = 1'b0;
    line = "";
    while (!ok && !$feof(fd)) begin
      rc = $fgets(s, fd);
      if (rc > 0 && s.len() > 0 && s[0] != "#" && s[0] != "\n") begin
        line = s;
        ok   = 1'b1;
      end
    end
  endtask

  // Jacobian (X, Y, Z) stands for (X/Z^2, Y/Z^3)
  task automatic check_result(input int tn, input bit exp_inf, input int ex, input int ey);
    int z;
    int z2;
    int z3;
    z  = int'(o_res.z);
    z2 = mod_mul(z, z);
    z3 = mod_mul(z2, z);
    if (exp_inf) begin
      assert (z == 0)
        else report_mismatch($sformatf("test %0d: expected infinity, got Z = %0d", tn, z));
    end else begin
      assert (z != 0)
        else report_mismatch($sformatf("test %0d: unexpected point at infinity", tn));
      assert (int'(o_res.x) == mod_mul(ex, z2))
        else report_mismatch($sformatf("test %0d: X = %0d, expected x*Z^2 = %0d",
                                       tn, o_res.x, mod_mul(ex, z2)));
      assert (int'(o_res.y) == mod_mul(ey, z3))
        else report_mismatch($sformatf("test %0d: Y = %0d, expected y*Z^3 = %0d",
                                       tn, o_res.y, mod_mul(ey, z3)));
    end
  endtask

  // Streams the list KEY_BITS times and takes exactly one result
  task automatic run_test(input int tn, input int n, input bit exp_inf, input int ex,
                          input int ey);
    int total;
    int sent;
    int cycles;
    bit got;
    total  = n * KEY_BITS;
    sent   = 0;
    cycles = 0;
    got    = 1'b0;
    i_num_in   <= 16'(n);
    i_item     <= items[0];
    i_item_val <= 1'b1;
    while (!got) begin
      @(posedge i_clk);
      cycles++;
      if (uut.u_core.u_hs_chk.fail_cnt != 0) begin
        $display("Handshake assertion failed at %0d ns in test %0d", $time, tn);
        end_with_failure();
      end
      if (i_item_val && o_item_rdy) begin
        sent++;
        if (sent < total) i_item <= items[sent % n];
        else i_item_val <= 1'b0;
      end
      if (o_res_val && i_res_rdy) begin
        assert (sent == total)
          else report_mismatch($sformatf("test %0d: result after only %0d of %0d items",
                                         tn, sent, total));
        check_result(tn, exp_inf, ex, ey);
        got = 1'b1;
      end
      i_res_rdy <= (($urandom % 3) != 0);   // Stall about one cycle in three
      if (!got && cycles >= MAX_WAIT) begin
        $display("Timeout at %0d ns: test %0d gave no result within %0d cycles",
                 $time, tn, MAX_WAIT);
        end_with_failure();
      end
    end
    @(posedge i_clk);
    assert (!o_res_val)
      else report_mismatch($sformatf("test %0d: a second result was presented", tn));
  endtask

  initial begin
    string     line;
    bit        ok;
    int        rc;
    int        n;
    int        exp_inf;
    int        ex;
    int        ey;
    int        scl;
    int        px;
    int        py;
    msm_item_t it;
    void'($urandom(13288));
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_item     = '0;
    i_item_val = 1'b0;
    i_num_in   = '0;
    i_res_rdy  = 1'b0;
    test_cnt   = 0;
    fd = $fopen("verification/msm_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file verification/msm_input.txt");
      end_with_failure();
    end
    repeat (16) @(posedge i_clk);
    i_rst     <= 1'b0;
    i_res_rdy <= 1'b1;

    read_line(line, ok);
    while (ok) begin
      rc = $sscanf(line, "%d", n);
      if (rc != 1 || n < 1) reject_line(line);
      items.delete();
      repeat (n) begin
        read_line(line, ok);
        rc = 0;
        if (ok) rc = $sscanf(line, "%h %d %d", scl, px, py);
        if (rc != 3) reject_line(line);
        it.scl  = 16'(scl);
        it.pt.x = fe_t'(px);
        it.pt.y = fe_t'(py);
        items.push_back(it);
      end
      read_line(line, ok);
      rc = 0;
      if (ok) rc = $sscanf(line, "%d %d %d", exp_inf, ex, ey);
      if (rc != 3) reject_line(line);
      test_cnt++;
      run_test(test_cnt, n, exp_inf != 0, ex, ey);
      read_line(line, ok);
    end
    $fclose(fd);

    if (test_cnt > 0 && uut.u_core.u_hs_chk.fail_cnt == 0) begin
      $display("Runs completed: %0d", test_cnt);
      $display("Done: no errors");
      $finish;
    end else begin
      if (test_cnt == 0) $display("No test found in stimulus file");
      else $display("Handshake assertion failed during the run");
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: verification/msm_assert.sv
// Handshake assertions bound into the MSM core
`timescale 1ns/1ps
`default_nettype none

module msm_assert (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_item_rdy,
  input  curve_pkg::jac_pt_t i_res,
  input  logic               i_res_val,
  input  logic               i_res_rdy,
  input  logic               i_add_req_val,
  input  logic               i_dbl_req_val
);

  int unsigned fail_cnt = 0;   // Read by the testbench at the end of the run

  // A stalled result keeps both its valid and its value
  res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val && !i_res_rdy |=> i_res_val && $stable(i_res))
    else begin
      $error("Result changed or dropped while stalled");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge i_clk)
    i_rst |=> !i_res_val && !i_add_req_val && !i_dbl_req_val)
    else begin
      $error("Valid output high right after a reset cycle");
      fail_cnt++;
    end

  // No item is taken while the core sits in reset
  reset_no_take: assert property (@(posedge i_clk)
    i_rst |-> !i_item_rdy)
    else begin
      $error("Item ready high during reset");
      fail_cnt++;
    end

  // Only one point unit works for the core at a time
  one_unit: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_add_req_val && i_dbl_req_val))
    else begin
      $error("Add and double requests pending together");
      fail_cnt++;
    end

endmodule

bind msm_core msm_assert u_hs_chk (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_item_rdy    (o_item_rdy),
  .i_res         (o_res),
  .i_res_val     (o_res_val),
  .i_res_rdy     (i_res_rdy),
  .i_add_req_val (o_add_req_val),
  .i_dbl_req_val (o_dbl_req_val)
);

`default_nettype wire

// File: logic/msm_top.sv
// MSM top: core, point adder, point doubler and one shared modular multiplier
`timescale 1ns/1ps
`default_nettype none

module msm_top #(
  parameter int P        = field_pkg::P_DEFAULT,
  parameter int KEY_BITS = 8
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  curve_pkg::msm_item_t i_item,
  input  logic                 i_item_val,
  output logic                 o_item_rdy,
  input  logic [15:0]          i_num_in,
  output curve_pkg::jac_pt_t   o_res,
  output logic                 o_res_val,
  input  logic                 i_res_rdy
);
  import field_pkg::*;
  import curve_pkg::*;

  jac_pt_t  add_acc, add_sum, dbl_pt, dbl_res;
  aff_pt_t  add_pt;
  logic     add_req_val, add_req_rdy, add_rsp_val, add_rsp_dbl;
  logic     dbl_req_val, dbl_req_rdy, dbl_rsp_val;
  mul_req_t add_mul_req, dbl_mul_req, mul_req;
  mul_rsp_t mul_rsp, arb_rsp;
  logic     add_mul_val, add_mul_rdy, add_mul_rsp_val;   // Arbiter port 0
  logic     dbl_mul_val, dbl_mul_rdy, dbl_mul_rsp_val;   // Arbiter port 1
  logic     mul_req_val, mul_rsp_val;

  msm_core #(
    .P        (P),
    .KEY_BITS (KEY_BITS)
  ) u_core (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_item        (i_item),
    .i_item_val    (i_item_val),
    .o_item_rdy    (o_item_rdy),
    .i_num_in      (i_num_in),
    .o_res         (o_res),
    .o_res_val     (o_res_val),
    .i_res_rdy     (i_res_rdy),
    .o_add_req_val (add_req_val),
    .o_add_acc     (add_acc),
    .o_add_pt      (add_pt),
    .i_add_req_rdy (add_req_rdy),
    .i_add_rsp_val (add_rsp_val),
    .i_add_rsp     (add_sum),
    .i_add_rsp_dbl (add_rsp_dbl),
    .o_dbl_req_val (dbl_req_val),
    .o_dbl_pt      (dbl_pt),
    .i_dbl_req_rdy (dbl_req_rdy),
    .i_dbl_rsp_val (dbl_rsp_val),
    .i_dbl_rsp     (dbl_res)
  );

  ec_pt_add #(
    .P (P)
  ) u_add (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_acc         (add_acc),
    .i_pt          (add_pt),
    .i_req_val     (add_req_val),
    .o_req_rdy     (add_req_rdy),
    .o_sum         (add_sum),
    .o_sum_val     (add_rsp_val),
    .o_sum_dbl     (add_rsp_dbl),
    .o_mul_req     (add_mul_req),
    .o_mul_req_val (add_mul_val),
    .i_mul_req_rdy (add_mul_rdy),
    .i_mul_rsp     (arb_rsp),
    .i_mul_rsp_val (add_mul_rsp_val)
  );

  ec_pt_dbl #(
    .P (P)
  ) u_dbl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_pt          (dbl_pt),
    .i_req_val     (dbl_req_val),
    .o_req_rdy     (dbl_req_rdy),
    .o_pt          (dbl_res),
    .o_pt_val      (dbl_rsp_val),
    .o_mul_req     (dbl_mul_req),
    .o_mul_req_val (dbl_mul_val),
    .i_mul_req_rdy (dbl_mul_rdy),
    .i_mul_rsp     (arb_rsp),
    .i_mul_rsp_val (dbl_mul_rsp_val)
  );

  mul_arbiter u_arb (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_req0        (add_mul_req),
    .i_req0_val    (add_mul_val),
    .o_req0_rdy    (add_mul_rdy),
    .i_req1        (dbl_mul_req),
    .i_req1_val    (dbl_mul_val),
    .o_req1_rdy    (dbl_mul_rdy),
    .o_mul_req     (mul_req),
    .o_mul_req_val (mul_req_val),
    .i_mul_rsp     (mul_rsp),
    .i_mul_rsp_val (mul_rsp_val),
    .o_rsp0_val    (add_mul_rsp_val),
    .o_rsp1_val    (dbl_mul_rsp_val),
    .o_rsp         (arb_rsp)
  );

  mod_mul_pipe #(
    .P (P)
  ) u_mul (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (mul_req),
    .i_req_val (mul_req_val),
    .o_rsp     (mul_rsp),
    .o_rsp_val (mul_rsp_val)
  );

endmodule

`default_nettype wire

// File: logic/msm_core.sv
// MSM core running MSB-first double-and-add over the looping scalar/point stream
`timescale 1ns/1ps
`default_nettype none

module msm_core #(
  parameter int P        = field_pkg::P_DEFAULT,
  parameter int KEY_BITS = 8
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  curve_pkg::msm_item_t i_item,
  input  logic                 i_item_val,
  output logic                 o_item_rdy,
  input  logic [15:0]          i_num_in,
  output curve_pkg::jac_pt_t   o_res,
  output logic                 o_res_val,
  input  logic                 i_res_rdy,
  output logic                 o_add_req_val,
  output curve_pkg::jac_pt_t   o_add_acc,
  output curve_pkg::aff_pt_t   o_add_pt,
  input  logic                 i_add_req_rdy,
  input  logic                 i_add_rsp_val,
  input  curve_pkg::jac_pt_t   i_add_rsp,
  input  logic                 i_add_rsp_dbl,
  output logic                 o_dbl_req_val,
  output curve_pkg::jac_pt_t   o_dbl_pt,
  input  logic                 i_dbl_req_rdy,
  input  logic                 i_dbl_rsp_val,
  input  curve_pkg::jac_pt_t   i_dbl_rsp
);
  import field_pkg::*;
  import curve_pkg::*;

  localparam int               BIT_W   = $clog2(KEY_BITS_MAX);
  localparam fe_t              PF      = fe_t'(P);
  localparam logic [BIT_W-1:0] TOP_BIT = BIT_W'(KEY_BITS - 1);

  typedef enum logic [2:0] {
    S_IDLE, S_ADD, S_ADD_WAIT, S_DBL, S_DBL_WAIT, S_FINISHED
  } state_t;

  state_t           state;
  state_t           item_next;   // Where to go once the current item is done
  jac_pt_t          acc;
  aff_pt_t          pt_in;
  logic [15:0]      num_in;
  logic [15:0]      num_cur;
  logic [15:0]      in_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             redo;        // Doubling stands in for an equal-point add
  logic             res_free;
  logic             take;
  logic             last_item;

  assign res_free   = !o_res_val || i_res_rdy;
  assign o_item_rdy = !i_rst && ((state == S_ADD) || (state == S_IDLE && res_free));
  assign take       = o_item_rdy && i_item_val;
  assign num_cur    = (state == S_IDLE) ? i_num_in : num_in;   // Count taken with first item
  assign last_item  = (in_cnt == num_cur - 16'd1);

  // Fold coordinates at or above P back into range
  assign pt_in.x = fe_add(i_item.pt.x, '0, PF);
  assign pt_in.y = fe_add(i_item.pt.y, '0, PF);

  always_comb begin
    item_next = S_ADD;
    if (last_item) item_next = (bit_cnt == '0) ? S_FINISHED : S_DBL;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= S_IDLE;
      acc           <= '0;   // Infinity
      in_cnt        <= '0;
      bit_cnt       <= TOP_BIT;
      redo          <= 1'b0;
      o_res_val     <= 1'b0;
      o_add_req_val <= 1'b0;
      o_dbl_req_val <= 1'b0;
    end else begin
      if (o_res_val && i_res_rdy) o_res_val <= 1'b0;
      if (o_add_req_val && i_add_req_rdy) o_add_req_val <= 1'b0;
      if (o_dbl_req_val && i_dbl_req_rdy) o_dbl_req_val <= 1'b0;

      case (state)
        S_IDLE, S_ADD: begin
          if (take) begin
            if (state == S_IDLE) num_in <= i_num_in;
            if (i_item.scl[bit_cnt]) begin
              o_add_acc     <= acc;
              o_add_pt      <= pt_in;
              o_add_req_val <= 1'b1;
              state         <= S_ADD_WAIT;
            end else begin
              in_cnt <= last_item ? '0 : in_cnt + 16'd1;   // Clear bit consumes the item
              state  <= item_next;
            end
          end
        end
        S_ADD_WAIT: begin
          if (i_add_rsp_val) begin
            if (i_add_rsp_dbl) begin
              o_dbl_pt      <= i_add_rsp;   // Unchanged accumulator
              o_dbl_req_val <= 1'b1;
              redo          <= 1'b1;
              state         <= S_DBL_WAIT;
            end else begin
              acc    <= i_add_rsp;
              in_cnt <= last_item ? '0 : in_cnt + 16'd1;
              state  <= item_next;
            end
          end
        end
        S_DBL: begin
          o_dbl_pt      <= acc;
          o_dbl_req_val <= 1'b1;
          redo          <= 1'b0;
          state         <= S_DBL_WAIT;
        end
        S_DBL_WAIT: begin
          if (i_dbl_rsp_val) begin
            acc <= i_dbl_rsp;
            if (redo) begin
              in_cnt <= last_item ? '0 : in_cnt + 16'd1;
              state  <= item_next;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;   // Next pass works one bit lower
              state   <= S_ADD;
            end
          end
        end
        S_FINISHED: begin
          if (res_free) begin
            o_res     <= acc;
            o_res_val <= 1'b1;
            acc       <= '0;
            in_cnt    <= '0;
            bit_cnt   <= TOP_BIT;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/ec_pt_dbl.sv
// Point doubler: Jacobian doubling for a = 0 over the shared multiplier
`timescale 1ns/1ps
`default_nettype none

module ec_pt_dbl #(
  parameter int P = field_pkg::P_DEFAULT
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  curve_pkg::jac_pt_t  i_pt,
  input  logic                i_req_val,
  output logic                o_req_rdy,
  output curve_pkg::jac_pt_t  o_pt,
  output logic                o_pt_val,
  output field_pkg::mul_req_t o_mul_req,
  output logic                o_mul_req_val,
  input  logic                i_mul_req_rdy,
  input  field_pkg::mul_rsp_t i_mul_rsp,
  input  logic                i_mul_rsp_val
);
  import field_pkg::*;
  import curve_pkg::*;

  localparam fe_t PF = fe_t'(P);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_t;

  state_t     state;
  logic [2:0] step;
  jac_pt_t    pt;
  fe_t        a, b, c, d, e, x3;
  fe_t        mul_out, xb, s, c8;

  assign o_req_rdy     = (state == S_IDLE);
  assign o_mul_req_val = (state == S_ISSUE);
  assign mul_out       = i_mul_rsp.prod;
  assign xb            = fe_add(pt.x, b, PF);
  assign s             = fe_sub(fe_sub(mul_out, a, PF), c, PF);   // (X+B)^2 - A - C
  assign c8            = fe_add(fe_add(fe_add(c, c, PF), fe_add(c, c, PF), PF),
                                fe_add(fe_add(c, c, PF), fe_add(c, c, PF), PF), PF);

  always_comb begin
    o_mul_req.tag = 1'b0;
    case (step)
      3'd0:    begin o_mul_req.a = pt.x; o_mul_req.b = pt.x; end   // A
      3'd1:    begin o_mul_req.a = pt.y; o_mul_req.b = pt.y; end   // B
      3'd2:    begin o_mul_req.a = b;    o_mul_req.b = b;    end   // C
      3'd3:    begin o_mul_req.a = xb;   o_mul_req.b = xb;   end
      3'd4:    begin o_mul_req.a = e;    o_mul_req.b = e;    end   // F = E^2
      3'd5:    begin o_mul_req.a = e;    o_mul_req.b = fe_sub(d, x3, PF); end
      default: begin o_mul_req.a = pt.y; o_mul_req.b = pt.z; end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      o_pt_val <= 1'b0;
    end else begin
      o_pt_val <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_req_val) begin
            pt    <= i_pt;
            step  <= '0;
            state <= S_ISSUE;
          end
        end
        S_ISSUE: if (i_mul_req_rdy) state <= S_WAIT;
        S_WAIT: begin
          if (i_mul_rsp_val) begin
            state <= S_ISSUE;
            step  <= step + 3'd1;
            case (step)
              3'd0: begin
                a <= mul_out;
                e <= fe_add(mul_out, fe_add(mul_out, mul_out, PF), PF);   // E = 3A
              end
              3'd1: b  <= mul_out;
              3'd2: c  <= mul_out;
              3'd3: d  <= fe_add(s, s, PF);
              3'd4: x3 <= fe_sub(mul_out, fe_add(d, d, PF), PF);
              3'd5: o_pt.y <= fe_sub(mul_out, c8, PF);
              default: begin
                // Z3 = 2YZ, stays zero for infinity
                o_pt.x   <= x3;
                o_pt.z   <= fe_add(mul_out, mul_out, PF);
                o_pt_val <= 1'b1;
                state    <= S_IDLE;
              end
            endcase
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/ec_pt_add.sv
// Point adder: mixed Jacobian plus affine addition, one shared multiply per step
`timescale 1ns/1ps
`default_nettype none

module ec_pt_add #(
  parameter int P = field_pkg::P_DEFAULT
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  curve_pkg::jac_pt_t  i_acc,
  input  curve_pkg::aff_pt_t  i_pt,
  input  logic                i_req_val,
  output logic                o_req_rdy,
  output curve_pkg::jac_pt_t  o_sum,
  output logic                o_sum_val,
  output logic                o_sum_dbl,
  output field_pkg::mul_req_t o_mul_req,
  output logic                o_mul_req_val,
  input  logic                i_mul_req_rdy,
  input  field_pkg::mul_rsp_t i_mul_rsp,
  input  logic                i_mul_rsp_val
);
  import field_pkg::*;
  import curve_pkg::*;

  localparam fe_t PF = fe_t'(P);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_t;

  state_t     state;
  logic [3:0] step;
  jac_pt_t    acc;
  aff_pt_t    pt;
  fe_t        zz, zzz, h, r, hh, hhh, v, x3, t;
  fe_t        mul_out;
  fe_t        r_new;

  assign o_req_rdy     = (state == S_IDLE);
  assign o_mul_req_val = (state == S_ISSUE);
  assign mul_out       = i_mul_rsp.prod;
  assign r_new         = fe_sub(mul_out, acc.y, PF);   // r = S2 - Y1

  // Operands for each product step
  always_comb begin
    o_mul_req.tag = 1'b0;
    case (step)
      4'd0:    begin o_mul_req.a = acc.z; o_mul_req.b = acc.z; end   // Z1^2
      4'd1:    begin o_mul_req.a = pt.x;  o_mul_req.b = zz;    end   // U2
      4'd2:    begin o_mul_req.a = acc.z; o_mul_req.b = zz;    end   // Z1^3
      4'd3:    begin o_mul_req.a = pt.y;  o_mul_req.b = zzz;   end   // S2
      4'd4:    begin o_mul_req.a = h;     o_mul_req.b = h;     end
      4'd5:    begin o_mul_req.a = h;     o_mul_req.b = hh;    end
      4'd6:    begin o_mul_req.a = acc.x; o_mul_req.b = hh;    end   // V = X1*H^2
      4'd7:    begin o_mul_req.a = r;     o_mul_req.b = r;     end
      4'd8:    begin o_mul_req.a = r;     o_mul_req.b = fe_sub(v, x3, PF); end
      4'd9:    begin o_mul_req.a = acc.y; o_mul_req.b = hhh;   end
      default: begin o_mul_req.a = acc.z; o_mul_req.b = h;     end   // Z3
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      o_sum_val <= 1'b0;
    end else begin
      o_sum_val <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_req_val) begin
            acc       <= i_acc;
            pt        <= i_pt;
            step      <= '0;
            o_sum_dbl <= 1'b0;
            if (i_acc.z == '0) begin
              // Infinity plus P is just P lifted to Z = 1
              o_sum     <= '{x: i_pt.x, y: i_pt.y, z: fe_t'(1)};
              o_sum_val <= 1'b1;
            end else begin
              state <= S_ISSUE;
            end
          end
        end
        S_ISSUE: if (i_mul_req_rdy) state <= S_WAIT;
        S_WAIT: begin
          if (i_mul_rsp_val) begin
            state <= S_ISSUE;
            step  <= step + 4'd1;
            case (step)
              4'd0: zz  <= mul_out;
              4'd1: h   <= fe_sub(mul_out, acc.x, PF);   // H = U2 - X1
              4'd2: zzz <= mul_out;
              4'd3: begin
                r <= r_new;
                if (h == '0) begin
                  // Same x: equal points go to the doubler, opposite ones cancel
                  state     <= S_IDLE;
                  o_sum_val <= 1'b1;
                  o_sum_dbl <= (r_new == '0);
                  o_sum     <= (r_new == '0) ? acc : '0;
                end
              end
              4'd4: hh  <= mul_out;
              4'd5: hhh <= mul_out;
              4'd6: v   <= mul_out;
              4'd7: x3  <= fe_sub(fe_sub(mul_out, hhh, PF), fe_add(v, v, PF), PF);
              4'd8: t   <= mul_out;
              4'd9: o_sum.y <= fe_sub(t, mul_out, PF);
              default: begin
                o_sum.x   <= x3;
                o_sum.z   <= mul_out;
                o_sum_val <= 1'b1;
                state     <= S_IDLE;
              end
            endcase
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mul_arbiter.sv
// Multiplier arbiter: round-robin grant between two requesters, responses routed back by tag
`timescale 1ns/1ps
`default_nettype none

module mul_arbiter (
  input  logic                i_clk,
  input  logic                i_rst,
  input  field_pkg::mul_req_t i_req0,
  input  logic                i_req0_val,
  output logic                o_req0_rdy,
  input  field_pkg::mul_req_t i_req1,
  input  logic                i_req1_val,
  output logic                o_req1_rdy,
  output field_pkg::mul_req_t o_mul_req,
  output logic                o_mul_req_val,
  input  field_pkg::mul_rsp_t i_mul_rsp,
  input  logic                i_mul_rsp_val,
  output logic                o_rsp0_val,
  output logic                o_rsp1_val,
  output field_pkg::mul_rsp_t o_rsp
);
  import field_pkg::*;

  logic last_gnt;   // High when requester 1 won last
  logic gnt0;
  logic gnt1;

  // Requester 1 wins alone, or on contention when 0 went last
  always_comb begin
    gnt1 = i_req1_val && (!i_req0_val || !last_gnt);
    gnt0 = i_req0_val && !gnt1;
    o_mul_req     = gnt1 ? i_req1 : i_req0;
    o_mul_req.tag = gnt1;
  end

  assign o_req0_rdy    = gnt0;   // Multiplier never stalls
  assign o_req1_rdy    = gnt1;
  assign o_mul_req_val = gnt0 || gnt1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last_gnt <= 1'b0;
    end else if (gnt0 || gnt1) begin
      last_gnt <= gnt1;
    end
  end

  assign o_rsp      = i_mul_rsp;
  assign o_rsp0_val = i_mul_rsp_val && !i_mul_rsp.tag;
  assign o_rsp1_val = i_mul_rsp_val && i_mul_rsp.tag;

endmodule

`default_nettype wire

// File: logic/mod_mul_pipe.sv
// Modular multiplier: product, reduction and output in three register stages, tag carried along
`timescale 1ns/1ps
`default_nettype none

module mod_mul_pipe #(
  parameter int P = field_pkg::P_DEFAULT
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  field_pkg::mul_req_t i_req,
  input  logic                i_req_val,
  output field_pkg::mul_rsp_t o_rsp,
  output logic                o_rsp_val
);
  import field_pkg::*;

  logic [2*FE_BITS-1:0] prod_s1;   // Full product
  fe_t                  red_s2;    // Reduced mod P
  logic [1:0]           tag_s;
  logic [1:0]           val_s;

  always_ff @(posedge i_clk) begin
    prod_s1    <= i_req.a * i_req.b;
    red_s2     <= fe_t'(prod_s1 % P);
    o_rsp.prod <= red_s2;
    tag_s      <= {tag_s[0], i_req.tag};
    o_rsp.tag  <= tag_s[1];
  end

  // Valid shifts alongside the data, no stall
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_s     <= '0;
      o_rsp_val <= 1'b0;
    end else begin
      val_s     <= {val_s[0], i_req_val};
      o_rsp_val <= val_s[1];
    end
  end

endmodule

`default_nettype wire

// File: logic/curve_pkg.sv
// Curve package: affine and Jacobian point structs and the input stream beat
`default_nettype none

package curve_pkg;

  localparam int KEY_BITS_MAX = 16;

  typedef struct packed {
    field_pkg::fe_t x;
    field_pkg::fe_t y;
  } aff_pt_t;

  // Z of zero is the point at infinity
  typedef struct packed {
    field_pkg::fe_t x;
    field_pkg::fe_t y;
    field_pkg::fe_t z;
  } jac_pt_t;

  // One beat of the looping scalar/point stream
  typedef struct packed {
    logic [KEY_BITS_MAX-1:0] scl;   // Only the low KEY_BITS are used
    aff_pt_t                 pt;
  } msm_item_t;

endpackage

`default_nettype wire

// File: logic/field_pkg.sv
// Field package: prime field element type, multiplier transfer structs, modular add/sub/neg
`default_nettype none

package field_pkg;

  localparam int FE_BITS   = 13;
  localparam int P_DEFAULT = 8191;

  typedef logic [FE_BITS-1:0] fe_t;

  // Request toward the shared multiplier
  typedef struct packed {
    fe_t  a;
    fe_t  b;
    logic tag;   // Requester index, stamped by arbiter
  } mul_req_t;

  typedef struct packed {
    fe_t  prod;
    logic tag;
  } mul_rsp_t;

  // Operands are expected below p
  function automatic fe_t fe_add(fe_t a, fe_t b, fe_t p);
    logic [FE_BITS:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, p}) s = s - {1'b0, p};
    return s[FE_BITS-1:0];
  endfunction

  function automatic fe_t fe_neg(fe_t a, fe_t p);
    return (a == '0) ? '0 : p - a;
  endfunction

  function automatic fe_t fe_sub(fe_t a, fe_t b, fe_t p);
    return fe_add(a, fe_neg(b, p), p);
  endfunction

endpackage

`default_nettype wire
